// ==== fixed_point_pkg.sv ====
package fixed_point_pkg;

	localparam int WORD_W = 32;
	localparam int HALF_W = 16;

	// Q formats
	localparam int COEF_FRAC = 27;
	localparam int OUT_FRAC = 12;
	localparam int Q31_FRAC = 31;

	typedef logic signed [WORD_W-1:0] word_t;

	localparam word_t WORD_MAX = 32'sh7fff_ffff;
	localparam word_t WORD_MIN = 32'sh8000_0000;
	localparam word_t COEF_ONE = 32'sd1 <<< COEF_FRAC;
	localparam word_t K_LIMIT = 32'sd32750 <<< 16;

	// Autocorrelation words use l_word, stored coefficients use hi
	typedef union packed {
		word_t l_word;
		struct packed {
			logic signed [HALF_W-1:0] hi;
			logic [HALF_W-1:0] lo;
		} half;
	} scratch_word_t;

	function automatic word_t sat_word(input logic signed [63:0] v);
		if (v > WORD_MAX)
			return WORD_MAX;
		else if (v < WORD_MIN)
			return WORD_MIN;
		return v[WORD_W-1:0];
	endfunction

	// Product of two words, arithmetic shift, then saturate
	function automatic word_t mul_shift(input word_t x, input word_t y, input int shift);
		logic signed [63:0] prod;
		prod = x * y;
		return sat_word(prod >>> shift);
	endfunction

	function automatic word_t sat_add(input word_t x, input word_t y);
		logic signed [63:0] sum;
		sum = x + y;
		return sat_word(sum);
	endfunction

endpackage

// ==== scratch_map_pkg.sv ====
package scratch_map_pkg;

	localparam int ADDR_W = 11;

	// Prediction order, so ORDER + 1 coefficients
	localparam int ORDER = 10;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [3:0] idx_t;

	// All regions 16-aligned
	// word n of a region sits at base + n
	localparam addr_t R_BASE = 11'h100;
	localparam addr_t A_BASE = 11'h110;
	localparam addr_t RC_BASE = 11'h120;

endpackage

// ==== reflection_divider.sv ====
`timescale 1ns/1ps

module reflection_divider (
	input logic clock,
	input logic reset,
	input logic div_start,
	input fixed_point_pkg::word_t div_num,
	input fixed_point_pkg::word_t div_den,
	output logic div_done,
	output fixed_point_pkg::word_t div_quot
);
	import fixed_point_pkg::*;

	logic busy;
	logic [4:0] count;
	logic [WORD_W-1:0] num_mag;
	logic [WORD_W-1:0] rem;
	logic [WORD_W-1:0] den;
	logic [WORD_W-2:0] quot;
	logic [WORD_W-2:0] quot_next;
	logic flip;
	logic sat;
	logic [WORD_W:0] shifted;
	logic [WORD_W:0] trial;
	logic bit_now;
	word_t mag;

	assign num_mag = div_num[WORD_W-1] ? -div_num : div_num;

	// One restoring step per cycle
	assign shifted = {rem, 1'b0};
	assign trial = shifted - {1'b0, den};
	assign bit_now = ~trial[WORD_W];
	assign quot_next = {quot[WORD_W-3:0], bit_now};
	assign mag = sat ? WORD_MAX : word_t'({1'b0, quot_next});

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
			div_done <= 1'b0;
		end else begin
			div_done <= 1'b0;
			if (div_start) begin
				busy <= 1'b1;
				count <= '0;
			end else if (busy) begin
				count <= count + 5'd1;
				if (count == 5'd30) begin
					busy <= 1'b0;
					div_done <= 1'b1;
				end
			end
		end
	end

	// k carries the opposite sign of the correlation sum
	always_ff @(posedge clock) begin
		if (div_start) begin
			rem <= num_mag;
			den <= div_den;
			quot <= '0;
			sat <= (num_mag >= div_den);
			flip <= ~div_num[WORD_W-1] && (div_num != '0);
		end else if (busy) begin
			rem <= bit_now ? trial[WORD_W-1:0] : shifted[WORD_W-1:0];
			quot <= quot_next;
			if (count == 5'd30)
				div_quot <= flip ? -mag : mag;
		end
	end

endmodule

// ==== error_update.sv ====
`timescale 1ns/1ps

module error_update (
	input logic clock,
	input logic reset,
	input logic err_load,
	input fixed_point_pkg::word_t r0,
	input logic err_start,
	input fixed_point_pkg::word_t k,
	output logic err_done,
	output fixed_point_pkg::word_t alp
);
	import fixed_point_pkg::*;

	logic [1:0] stage;
	word_t k_sq;
	word_t one_minus;

	always_ff @(posedge clock) begin
		if (reset) begin
			stage <= '0;
			err_done <= 1'b0;
		end else begin
			stage <= {stage[0], err_start};
			err_done <= stage[1];
		end
	end

	// k squared, then 1 - k^2, then scale alp
	always_ff @(posedge clock) begin
		if (err_start)
			k_sq <= mul_shift(k, k, Q31_FRAC);
		if (stage[0])
			one_minus <= WORD_MAX - k_sq;
		if (err_load)
			alp <= r0;
		else if (stage[1])
			alp <= mul_shift(alp, one_minus, Q31_FRAC);
	end

endmodule

// ==== coefficient_bank.sv ====
`timescale 1ns/1ps

module coefficient_bank (
	input logic clock,
	input logic reset,
	input logic init,
	input logic save,
	input logic restore,
	input logic upd_start,
	input fixed_point_pkg::word_t k,
	input scratch_map_pkg::idx_t order,
	output logic upd_done,
	input scratch_map_pkg::idx_t a_index,
	output fixed_point_pkg::word_t a_value
);
	import fixed_point_pkg::*;
	import scratch_map_pkg::*;

	word_t a [0:ORDER];
	word_t a_next [0:ORDER];
	word_t a_saved [0:ORDER];

	logic busy;
	idx_t step;
	idx_t ord_reg;
	word_t k_reg;
	logic active;
	idx_t cur_j;
	idx_t cur_ord;
	word_t cur_k;
	logic last;

	// First term is taken straight from the start inputs
	assign active = upd_start | busy;
	assign cur_j = upd_start ? idx_t'(1) : step;
	assign cur_ord = upd_start ? order : ord_reg;
	assign cur_k = upd_start ? k : k_reg;
	assign last = (cur_j >= cur_ord);

	assign a_value = a[a_index];

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			step <= '0;
			upd_done <= 1'b0;
		end else begin
			upd_done <= 1'b0;
			if (active) begin
				busy <= ~last;
				step <= cur_j + 4'd1;
				upd_done <= last;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (active) begin
			k_reg <= cur_k;
			ord_reg <= cur_ord;
		end
		if (active && !last)
			a_next[cur_j] <= sat_add(a[cur_j], mul_shift(cur_k, a[cur_ord - cur_j], Q31_FRAC));
	end

	// Swap in a_next, new top coefficient is k in Q27
	always_ff @(posedge clock) begin
		if (init) begin
			for (int n = 0; n <= ORDER; n++)
				a[n] <= (n == 0) ? COEF_ONE : '0;
		end else if (restore) begin
			a <= a_saved;
		end else if (active && last) begin
			for (int n = 1; n <= ORDER; n++) begin
				if (n < cur_ord)
					a[n] <= a_next[n];
				else if (n == cur_ord)
					a[n] <= cur_k >>> (Q31_FRAC - COEF_FRAC);
			end
		end
	end

	// Fallback copy, kept across frames
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int n = 0; n <= ORDER; n++)
				a_saved[n] <= (n == 0) ? COEF_ONE : '0;
		end else if (save) begin
			a_saved <= a;
		end
	end

endmodule

// ==== recursion_control.sv ====
`timescale 1ns/1ps

module recursion_control (
	input logic clock,
	input logic reset,
	input logic start,
	output logic done,
	output scratch_map_pkg::addr_t mem_read_addr,
	input fixed_point_pkg::scratch_word_t mem_read_data,
	output logic mem_write_en,
	output scratch_map_pkg::addr_t mem_write_addr,
	output fixed_point_pkg::scratch_word_t mem_write_data,
	output logic div_start,
	output fixed_point_pkg::word_t div_num,
	output fixed_point_pkg::word_t div_den,
	input logic div_done,
	input fixed_point_pkg::word_t div_quot,
	output logic err_load,
	output fixed_point_pkg::word_t r0,
	output logic err_start,
	output fixed_point_pkg::word_t k,
	input logic err_done,
	input fixed_point_pkg::word_t alp,
	output logic init,
	output logic save,
	output logic restore,
	output logic upd_start,
	output scratch_map_pkg::idx_t order,
	input logic upd_done,
	output scratch_map_pkg::idx_t a_index,
	input fixed_point_pkg::word_t a_value
);
	import fixed_point_pkg::*;
	import scratch_map_pkg::*;

	enum logic [3:0] {
		S_IDLE,
		S_READ,
		S_LOAD,
		S_CORR,
		S_DIV,
		S_CHECK,
		S_UPD,
		S_WRITE_A,
		S_WRITE_RC
	} state;

	word_t r [0:ORDER];
	word_t acc;
	word_t rc0;
	word_t rc1;
	word_t rc_old0;
	word_t rc_old1;
	word_t rc_out;
	idx_t cnt;
	logic err_seen;
	logic upd_seen;
	logic unstable;
	logic k_over;
	logic both_done;

	// Q27 to Q12 with rounding, saturated to a half word
	function automatic logic signed [HALF_W-1:0] round_out(input word_t v);
		logic signed [WORD_W:0] wide;
		wide = v;
		wide = (wide + (33'sd1 <<< (COEF_FRAC - OUT_FRAC - 1))) >>> (COEF_FRAC - OUT_FRAC);
		if (wide > 33'sd32767)
			return 16'sh7fff;
		else if (wide < -33'sd32768)
			return 16'sh8000;
		return wide[HALF_W-1:0];
	endfunction

	assign mem_read_addr = {R_BASE[ADDR_W-1:4], cnt};
	assign div_num = acc;
	assign div_den = alp;
	assign r0 = r[0];
	assign both_done = (err_seen | err_done) & (upd_seen | upd_done);
	assign k_over = (k > K_LIMIT) || (k < -K_LIMIT);

	// Unstable frames fall back to the last good reflection coefficients
	assign rc_out = unstable ? ((cnt == 4'd0) ? rc_old0 : rc_old1)
		: ((cnt == 4'd0) ? rc0 : rc1);

	//////////////////////////////////////////////////
	// Strobes and memory writes
	//////////////////////////////////////////////////

	always_comb begin
		div_start = 1'b0;
		err_load = 1'b0;
		err_start = 1'b0;
		upd_start = 1'b0;
		init = 1'b0;
		save = 1'b0;
		restore = 1'b0;
		done = 1'b0;
		mem_write_en = 1'b0;
		mem_write_addr = {A_BASE[ADDR_W-1:4], cnt};
		mem_write_data = '0;
		a_index = order - cnt;
		case (state)
			S_LOAD: begin
				err_load = 1'b1;
				init = 1'b1;
			end
			S_CORR: begin
				div_start = (cnt >= order);
			end
			S_CHECK: begin
				if (order >= 4'd2 && k_over) begin
					restore = 1'b1;
				end else begin
					err_start = 1'b1;
					upd_start = 1'b1;
				end
			end
			S_UPD: begin
				save = both_done && (order == idx_t'(ORDER));
			end
			S_WRITE_A: begin
				a_index = cnt;
				mem_write_en = 1'b1;
				mem_write_data.half.hi = round_out(a_value);
			end
			S_WRITE_RC: begin
				mem_write_en = 1'b1;
				mem_write_addr = {RC_BASE[ADDR_W-1:4], cnt};
				mem_write_data.half.hi = rc_out[WORD_W-1:HALF_W];
				done = (cnt == 4'd1);
			end
			default: begin
				done = 1'b0;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
			cnt <= '0;
			order <= '0;
			unstable <= 1'b0;
			err_seen <= 1'b0;
			upd_seen <= 1'b0;
			rc_old0 <= '0;
			rc_old1 <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						state <= S_READ;
						cnt <= 4'd1;
						unstable <= 1'b0;
					end
				end
				S_READ: begin
					if (cnt == idx_t'(ORDER + 1))
						state <= S_LOAD;
					else
						cnt <= cnt + 4'd1;
				end
				S_LOAD: begin
					state <= S_CORR;
					cnt <= 4'd1;
					order <= 4'd1;
				end
				S_CORR: begin
					if (cnt >= order)
						state <= S_DIV;
					else
						cnt <= cnt + 4'd1;
				end
				S_DIV: begin
					if (div_done)
						state <= S_CHECK;
				end
				S_CHECK: begin
					err_seen <= 1'b0;
					upd_seen <= 1'b0;
					if (order >= 4'd2 && k_over) begin
						unstable <= 1'b1;
						cnt <= '0;
						state <= S_WRITE_A;
					end else begin
						state <= S_UPD;
					end
				end
				S_UPD: begin
					// Both units may finish in either order
					err_seen <= err_seen | err_done;
					upd_seen <= upd_seen | upd_done;
					if (both_done) begin
						if (order == idx_t'(ORDER)) begin
							rc_old0 <= rc0;
							rc_old1 <= rc1;
							cnt <= '0;
							state <= S_WRITE_A;
						end else begin
							order <= order + 4'd1;
							cnt <= 4'd1;
							state <= S_CORR;
						end
					end
				end
				S_WRITE_A: begin
					if (cnt == idx_t'(ORDER)) begin
						cnt <= '0;
						state <= S_WRITE_RC;
					end else begin
						cnt <= cnt + 4'd1;
					end
				end
				S_WRITE_RC: begin
					if (cnt == 4'd1) begin
						cnt <= '0;
						state <= S_IDLE;
					end else begin
						cnt <= cnt + 4'd1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Datapath registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		case (state)
			S_READ: r[cnt - 4'd1] <= mem_read_data.l_word;
			S_LOAD: acc <= r[1];
			S_CORR: begin
				if (cnt < order)
					acc <= sat_add(acc, mul_shift(r[cnt], a_value, COEF_FRAC));
			end
			S_DIV: begin
				if (div_done)
					k <= div_quot;
			end
			S_CHECK: begin
				if (order == 4'd1)
					rc0 <= k;
				if (order == 4'd2)
					rc1 <= k;
			end
			S_UPD: begin
				if (both_done && order != idx_t'(ORDER))
					acc <= r[order + 4'd1];
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== levinson_top.sv ====
`timescale 1ns/1ps

module levinson_top (
	input logic clock,
	input logic reset,
	input logic start,
	output logic done,
	output scratch_map_pkg::addr_t mem_read_addr,
	input fixed_point_pkg::scratch_word_t mem_read_data,
	output logic mem_write_en,
	output scratch_map_pkg::addr_t mem_write_addr,
	output fixed_point_pkg::scratch_word_t mem_write_data
);
	import fixed_point_pkg::*;
	import scratch_map_pkg::*;

	logic div_start;
	logic div_done;
	word_t div_num;
	word_t div_den;
	word_t div_quot;

	logic err_load;
	logic err_start;
	logic err_done;
	word_t r0;
	word_t k;
	word_t alp;

	logic init;
	logic save;
	logic restore;
	logic upd_start;
	logic upd_done;
	idx_t order;
	idx_t a_index;
	word_t a_value;

	recursion_control u_control (
		.clock(clock),
		.reset(reset),
		.start(start),
		.done(done),
		.mem_read_addr(mem_read_addr),
		.mem_read_data(mem_read_data),
		.mem_write_en(mem_write_en),
		.mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data),
		.div_start(div_start),
		.div_num(div_num),
		.div_den(div_den),
		.div_done(div_done),
		.div_quot(div_quot),
		.err_load(err_load),
		.r0(r0),
		.err_start(err_start),
		.k(k),
		.err_done(err_done),
		.alp(alp),
		.init(init),
		.save(save),
		.restore(restore),
		.upd_start(upd_start),
		.order(order),
		.upd_done(upd_done),
		.a_index(a_index),
		.a_value(a_value)
	);

	reflection_divider u_divider (
		.clock(clock),
		.reset(reset),
		.div_start(div_start),
		.div_num(div_num),
		.div_den(div_den),
		.div_done(div_done),
		.div_quot(div_quot)
	);

	error_update u_error (
		.clock(clock),
		.reset(reset),
		.err_load(err_load),
		.r0(r0),
		.err_start(err_start),
		.k(k),
		.err_done(err_done),
		.alp(alp)
	);

	coefficient_bank u_coefs (
		.clock(clock),
		.reset(reset),
		.init(init),
		.save(save),
		.restore(restore),
		.upd_start(upd_start),
		.k(k),
		.order(order),
		.upd_done(upd_done),
		.a_index(a_index),
		.a_value(a_value)
	);

endmodule

// ==== tb_ld_model.svh ====
`ifndef TB_LD_MODEL_SVH
`define TB_LD_MODEL_SVH

// Reference model of one frame, 64-bit intermediates throughout
localparam longint M_MAX = 64'sd2147483647;
localparam longint M_MIN = -64'sd2147483648;
localparam longint M_KLIM = 64'sd32750 * 64'sd65536;

int model_r [0:10];
int model_saved [0:10];
int model_rc_old [0:1];
logic [31:0] exp_word [0:12];
logic exp_unstable;

function automatic int clip(input longint v);
	if (v > M_MAX)
		return int'(M_MAX);
	else if (v < M_MIN)
		return int'(M_MIN);
	return int'(v);
endfunction

function automatic int mulq(input int x, input int y, input int sh);
	longint p;
	p = longint'(x) * longint'(y);
	return clip(p >>> sh);
endfunction

function automatic int addq(input int x, input int y);
	return clip(longint'(x) + longint'(y));
endfunction

// k = -sign(acc) * floor(|acc| * 2^31 / alp)
function automatic int kdiv(input int acc, input int alp);
	longint mag;
	longint den;
	longint q;
	mag = (acc < 0) ? -longint'(acc) : longint'(acc);
	den = longint'(alp) & 64'h0000_0000_ffff_ffff;
	if (mag >= den)
		q = M_MAX;
	else
		q = (mag <<< 31) / den;
	return (acc > 0) ? -int'(q) : int'(q);
endfunction

function automatic logic [15:0] to_q12(input int v);
	longint w;
	w = (longint'(v) + 64'sd16384) >>> 15;
	if (w > 64'sd32767)
		return 16'h7fff;
	else if (w < -64'sd32768)
		return 16'h8000;
	return w[15:0];
endfunction

task automatic model_reset();
	for (int j = 0; j <= 10; j++)
		model_saved[j] = (j == 0) ? (1 << 27) : 0;
	model_rc_old[0] = 0;
	model_rc_old[1] = 0;
endtask

task automatic compute_expected();
	int a [0:10];
	int an [0:10];
	int rc [0:1];
	int alp;
	int acc;
	int k;
	logic bad;
	bad = 1'b0;
	alp = model_r[0];
	rc[0] = 0;
	rc[1] = 0;
	for (int j = 0; j <= 10; j++)
		a[j] = (j == 0) ? (1 << 27) : 0;
	for (int i = 1; i <= 10 && !bad; i++) begin
		acc = model_r[i];
		for (int j = 1; j < i; j++)
			acc = addq(acc, mulq(model_r[j], a[i-j], 27));
		k = kdiv(acc, alp);
		if (i >= 2 && (longint'(k) > M_KLIM || longint'(k) < -M_KLIM)) begin
			bad = 1'b1;
		end else begin
			if (i <= 2)
				rc[i-1] = k;
			alp = mulq(alp, 32'h7fff_ffff - mulq(k, k, 31), 31);
			for (int j = 1; j < i; j++)
				an[j] = addq(a[j], mulq(k, a[i-j], 31));
			for (int j = 1; j < i; j++)
				a[j] = an[j];
			a[i] = k >>> 4;
		end
	end
	// Fallback to the last good frame
	if (bad) begin
		a = model_saved;
		rc = model_rc_old;
	end else begin
		model_saved = a;
		model_rc_old = rc;
	end
	exp_unstable = bad;
	for (int j = 0; j <= 10; j++)
		exp_word[j] = {to_q12(a[j]), 16'h0000};
	for (int m = 0; m < 2; m++)
		exp_word[11+m] = {rc[m][31:16], 16'h0000};
endtask

`endif

// ==== tb_levinson.sv ====
`timescale 1ns/1ps

module tb_levinson;

	localparam int CLK_PERIOD = 20;
	localparam int TABLE_ROWS = 6;
	localparam int RAND_ROWS = 4;
	localparam int NUM_ROWS = TABLE_ROWS + RAND_ROWS;
	localparam int FRAME_LIMIT = 1500;

	logic clock;
	logic reset;
	logic start;
	logic done;
	scratch_map_pkg::addr_t mem_read_addr;
	fixed_point_pkg::scratch_word_t mem_read_data;
	logic mem_write_en;
	scratch_map_pkg::addr_t mem_write_addr;
	fixed_point_pkg::scratch_word_t mem_write_data;

	logic [31:0] mem [0:2047];
	logic load_en;
	logic [10:0] load_addr;
	logic [31:0] load_data;
	int done_count;
	int write_count;
	int check_count;
	int mismatch_count;
	int fault_count;
	logic [15:0] lfsr_state;

	int row_r [0:NUM_ROWS-1][0:10];
	logic row_unstable [0:NUM_ROWS-1];
	logic row_busy [0:NUM_ROWS-1];

	`include "tb_ld_model.svh"

	levinson_top dut (
		.clock(clock),
		.reset(reset),
		.start(start),
		.done(done),
		.mem_read_addr(mem_read_addr),
		.mem_read_data(mem_read_data),
		.mem_write_en(mem_write_en),
		.mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// Scratch memory, one-cycle read
	initial begin
		mem_read_data = '0;
		for (int n = 0; n < 2048; n++)
			mem[n] = 32'h5a5a_0000 ^ (n * 32'h0001_0003);
	end

	always @(posedge clock) begin
		mem_read_data <= mem[mem_read_addr];
		if (load_en)
			mem[load_addr] <= load_data;
		if (mem_write_en)
			mem[mem_write_addr] <= mem_write_data;
	end

	always @(posedge clock) begin
		if (reset) begin
			done_count <= 0;
			write_count <= 0;
		end else begin
			if (done)
				done_count <= done_count + 1;
			if (mem_write_en)
				write_count <= write_count + 1;
		end
	end

	initial begin
		#(NUM_ROWS * FRAME_LIMIT * CLK_PERIOD);
		$display("watchdog expired before all frames finished");
		$display("Simulation failed");
		$finish;
	end

	// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
	task automatic random_bits(input int n, output logic [31:0] v);
		logic fb;
		v = '0;
		for (int b = 0; b < n; b++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			v = {v[30:0], fb};
		end
	endtask

	task automatic set_geometric(input int n, input longint r0, input int num, input int den,
		input logic alternate);
		longint v;
		v = r0;
		for (int j = 0; j <= 10; j++) begin
			row_r[n][j] = (alternate && j[0]) ? -int'(v) : int'(v);
			v = v * num / den;
		end
		row_unstable[n] = 1'b0;
		row_busy[n] = 1'b0;
	endtask

	// Small off-diagonal terms keep the frame well inside the stable region
	task automatic make_random_row(input int n);
		logic [31:0] bits;
		logic [31:0] sgn;
		int lim;
		random_bits(24, bits);
		row_r[n][0] = 32'h2000_0000 | bits;
		for (int j = 1; j <= 10; j++) begin
			lim = row_r[n][0] >>> (j + 2);
			random_bits(30, bits);
			random_bits(1, sgn);
			row_r[n][j] = sgn[0] ? -int'(bits % lim) : int'(bits % lim);
		end
		row_unstable[n] = 1'b0;
		row_busy[n] = 1'b0;
	endtask

	task automatic build_table();
		row_r[0] = '{1000, 0, 1000, 0, 0, 0, 0, 0, 0, 0, 0};
		row_unstable[0] = 1'b1;
		row_busy[0] = 1'b0;
		set_geometric(1, 64'sh1000_0000, 1, 2, 1'b0);
		row_busy[1] = 1'b1;
		row_r[2] = '{32'h0080_0000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
		row_unstable[2] = 1'b0;
		row_busy[2] = 1'b0;
		row_r[3] = '{5000, 0, -5000, 0, 0, 0, 0, 0, 0, 0, 0};
		row_unstable[3] = 1'b1;
		row_busy[3] = 1'b1;
		set_geometric(4, 64'sd1000000000, 3, 4, 1'b1);
		row_r[5] = '{1000, 0, 1000, 0, 0, 0, 0, 0, 0, 0, 0};
		row_unstable[5] = 1'b1;
		row_busy[5] = 1'b0;
		for (int n = TABLE_ROWS; n < NUM_ROWS; n++)
			make_random_row(n);
	endtask

	task automatic check_word(input logic [10:0] addr, input logic [31:0] expected);
		check_count++;
		assert (mem[addr] === expected)
		else begin
			mismatch_count++;
			$display("mismatch at %0t: word %h is %h, expected %h", $time, addr, mem[addr],
				expected);
		end
	endtask

	task automatic run_row(input int n);
		int base_done;
		int base_writes;
		int waited;
		for (int j = 0; j <= 10; j++) begin
			@(negedge clock);
			load_en = 1'b1;
			load_addr = scratch_map_pkg::R_BASE + 11'(j);
			load_data = row_r[n][j];
		end
		@(negedge clock);
		load_en = 1'b0;
		model_r = row_r[n];
		compute_expected();
		assert (exp_unstable == row_unstable[n])
		else begin
			fault_count++;
			$display("row %0d stability flag does not agree with the model", n);
		end
		base_done = done_count;
		base_writes = write_count;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		if (row_busy[n]) begin
			// A restarted frame would read the changed r[0]
			repeat (20) @(negedge clock);
			load_en = 1'b1;
			load_addr = scratch_map_pkg::R_BASE;
			load_data = row_r[n][0] >>> 1;
			@(negedge clock);
			load_en = 1'b0;
			start = 1'b1;
			@(negedge clock);
			start = 1'b0;
		end
		waited = 0;
		while (done_count == base_done && waited < FRAME_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (done_count == base_done) begin
			$display("row %0d never finished, done did not pulse", n);
			$display("Simulation failed");
			$finish;
		end else begin
			repeat (4) @(negedge clock);
			check_count++;
			assert (done_count == base_done + 1 && write_count == base_writes + 13)
			else begin
				fault_count++;
				$display("row %0d gave %0d done pulses and %0d writes", n,
					done_count - base_done, write_count - base_writes);
			end
			for (int j = 0; j <= 10; j++)
				check_word(scratch_map_pkg::A_BASE + 11'(j), exp_word[j]);
			for (int m = 0; m < 2; m++)
				check_word(scratch_map_pkg::RC_BASE + 11'(m), exp_word[11+m]);
		end
	endtask

	initial begin
		reset = 1'b1;
		start = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		check_count = 0;
		mismatch_count = 0;
		fault_count = 0;
		lfsr_state = 16'd2489;
		model_reset();
		build_table();
		repeat (8) @(negedge clock);
		reset = 1'b0;

		// Idle after reset
		repeat (20) begin
			@(negedge clock);
			check_count++;
			assert (done === 1'b0 && mem_write_en === 1'b0)
			else begin
				fault_count++;
				$display("done or write enable went high while idle");
			end
		end
		assert (done_count == 0 && write_count == 0)
		else begin
			fault_count++;
			$display("memory was written before any start");
		end

		for (int n = 0; n < NUM_ROWS; n++)
			run_row(n);

		repeat (5) @(negedge clock);
		$display("checks: %0d, mismatches: %0d, other errors: %0d", check_count,
			mismatch_count, fault_count);
		if (mismatch_count == 0 && fault_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+.
fixed_point_pkg.sv
scratch_map_pkg.sv
reflection_divider.sv
error_update.sv
coefficient_bank.sv
recursion_control.sv
levinson_top.sv
tb_levinson.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run; pass only if the pass message is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_levinson -o sim_levinson \
	&& ./obj_dir/sim_levinson | tee /dev/stderr | grep -q "Simulation completed successfully" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
